// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes of the supported subset, instr[6:0]
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal   = 7'b1101111;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct7 value that turns add into sub and srl into sra
  // the same bits sit in imm[11:5] of srai
  localparam logic [6:0] f7_alt = 7'b0100000;

endpackage

`default_nettype wire

// File: verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // class of ALU operation requested by the decoder
  typedef enum logic [1:0] {
    alu_op_add = 2'b00,
    alu_op_imm = 2'b01,
    alu_op_reg = 2'b10
  } alu_op_t;

  // function the ALU actually computes
  typedef enum logic [3:0] {
    alu_fn_add  = 4'd0,
    alu_fn_sub  = 4'd1,
    alu_fn_sll  = 4'd2,
    alu_fn_slt  = 4'd3,
    alu_fn_sltu = 4'd4,
    alu_fn_xor  = 4'd5,
    alu_fn_srl  = 4'd6,
    alu_fn_sra  = 4'd7,
    alu_fn_or   = 4'd8,
    alu_fn_and  = 4'd9
  } alu_fn_t;

  // source of the value written back to rd
  typedef enum logic [1:0] {
    wb_alu = 2'b00,
    wb_mem = 2'b01,
    wb_pc4 = 2'b10
  } wb_src_t;

endpackage

`default_nettype wire

// File: verilog/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire logic [31:0]         instr,
  output logic                     alu_src,
  output logic                     reg_w,
  output logic                     mem_r,
  output logic                     mem_w,
  output logic                     jump,
  output rv_core_pkg::alu_op_t     alu_op,
  output rv_core_pkg::wb_src_t     wb_src,
  output logic [31:0]              imm,
  output logic [4:0]               rs1,
  output logic [4:0]               rs2,
  output logic [4:0]               rd,
  output logic [2:0]               funct3,
  output logic                     funct7_alt
);

  logic [6:0] opcode;

  assign opcode = instr[6:0];

  // register fields sit at fixed positions in every format
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];

  // srai carries the same pattern in imm[11:5], so one compare covers OP and OP-IMM
  assign funct7_alt = (instr[31:25] == rv_isa_pkg::f7_alt);

  always_comb begin
    // unknown opcodes fall through as a no-op with nothing enabled
    alu_src = 1'b0;
    reg_w   = 1'b0;
    mem_r   = 1'b0;
    mem_w   = 1'b0;
    jump    = 1'b0;
    alu_op  = rv_core_pkg::alu_op_add;
    wb_src  = rv_core_pkg::wb_alu;
    imm     = 32'd0;
    case (opcode)
      rv_isa_pkg::op_load: begin
        alu_src = 1'b1;
        reg_w   = 1'b1;
        mem_r   = 1'b1;
        wb_src  = rv_core_pkg::wb_mem;
        imm     = {{20{instr[31]}}, instr[31:20]};
      end
      rv_isa_pkg::op_store: begin
        // address is rs1 plus the split S immediate, rs2 is the store data
        alu_src = 1'b1;
        mem_w   = 1'b1;
        imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      rv_isa_pkg::op_imm: begin
        alu_src = 1'b1;
        reg_w   = 1'b1;
        alu_op  = rv_core_pkg::alu_op_imm;
        imm     = {{20{instr[31]}}, instr[31:20]};
      end
      rv_isa_pkg::op_reg: begin
        reg_w   = 1'b1;
        alu_op  = rv_core_pkg::alu_op_reg;
      end
      rv_isa_pkg::op_auipc: begin
        alu_src = 1'b1;
        reg_w   = 1'b1;
        imm     = {instr[31:12], 12'd0};
      end
      rv_isa_pkg::op_jal: begin
        // the ALU forms the target, rd gets the link value
        alu_src = 1'b1;
        reg_w   = 1'b1;
        jump    = 1'b1;
        wb_src  = rv_core_pkg::wb_pc4;
        imm     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire logic [31:0]             rs1_data,
  input  wire logic [31:0]             rs2_data,
  input  wire logic [31:0]             pc,
  input  wire logic [31:0]             imm,
  input  wire logic                    alu_src,
  input  wire rv_core_pkg::alu_op_t    alu_op,
  input  wire logic [2:0]              funct3,
  input  wire logic                    funct7_alt,
  input  wire logic                    use_pc,
  output logic [31:0]                  alu_result
);

  rv_core_pkg::alu_fn_t alu_fn;
  logic [31:0]          op_a;
  logic [31:0]          op_b;

  // ALU control, sub only exists in the register form
  always_comb begin
    alu_fn = rv_core_pkg::alu_fn_add;
    if (alu_op != rv_core_pkg::alu_op_add) begin
      case (funct3)
        rv_isa_pkg::f3_add: begin
          if (alu_op == rv_core_pkg::alu_op_reg && funct7_alt) begin
            alu_fn = rv_core_pkg::alu_fn_sub;
          end
        end
        rv_isa_pkg::f3_sll:  alu_fn = rv_core_pkg::alu_fn_sll;
        rv_isa_pkg::f3_slt:  alu_fn = rv_core_pkg::alu_fn_slt;
        rv_isa_pkg::f3_sltu: alu_fn = rv_core_pkg::alu_fn_sltu;
        rv_isa_pkg::f3_xor:  alu_fn = rv_core_pkg::alu_fn_xor;
        rv_isa_pkg::f3_sr: begin
          alu_fn = funct7_alt ? rv_core_pkg::alu_fn_sra : rv_core_pkg::alu_fn_srl;
        end
        rv_isa_pkg::f3_or:   alu_fn = rv_core_pkg::alu_fn_or;
        rv_isa_pkg::f3_and:  alu_fn = rv_core_pkg::alu_fn_and;
        default:             alu_fn = rv_core_pkg::alu_fn_add;
      endcase
    end
  end

  // AUIPC and JAL add the immediate to the pc instead of rs1
  assign op_a = use_pc ? pc : rs1_data;
  assign op_b = alu_src ? imm : rs2_data;

  always_comb begin
    case (alu_fn)
      rv_core_pkg::alu_fn_sub:  alu_result = op_a - op_b;
      rv_core_pkg::alu_fn_sll:  alu_result = op_a << op_b[4:0];
      rv_core_pkg::alu_fn_slt:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::alu_fn_sltu: alu_result = {31'd0, op_a < op_b};
      rv_core_pkg::alu_fn_xor:  alu_result = op_a ^ op_b;
      rv_core_pkg::alu_fn_srl:  alu_result = op_a >> op_b[4:0];
      rv_core_pkg::alu_fn_sra:  alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
      rv_core_pkg::alu_fn_or:   alu_result = op_a | op_b;
      rv_core_pkg::alu_fn_and:  alu_result = op_a & op_b;
      default:                  alu_result = op_a + op_b;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [4:0]  rs1,
  input  wire logic [4:0]  rs2,
  input  wire logic        we,
  input  wire logic [4:0]  rd,
  input  wire logic [31:0] wd,
  output logic [31:0]      rs1_data,
  output logic [31:0]      rs2_data
);

  // x0 has no storage, only x1 to x31 are kept
  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

  // asynchronous reads, index zero always returns zero
  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// File: verilog/rv_lsu_apb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu_apb (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        mem_r,
  input  wire logic        mem_w,
  input  wire logic [31:0] addr,
  input  wire logic [31:0] wdata,
  output logic             stall,
  output logic [31:0]      load_data,
  output logic [31:0]      paddr,
  output logic             psel,
  output logic             penable,
  output logic             pwrite,
  output logic [31:0]      pwdata,
  input  wire logic [31:0] prdata,
  input  wire logic        pready,
  input  wire logic        pslverr
);

  typedef enum logic [1:0] {
    st_idle   = 2'b00,
    st_setup  = 2'b01,
    st_access = 2'b10
  } lsu_state_t;

  lsu_state_t state_q;
  lsu_state_t phase;
  logic       req;

  assign req = mem_r | mem_w;

  // setup is the first cycle a memory instruction is seen, so it is not registered
  always_comb begin
    phase = state_q;
    if (state_q == st_idle && req) begin
      phase = st_setup;
    end
  end

  // access ends on pready and the FSM drops back to idle for the next instruction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      case (phase)
        st_setup:  state_q <= st_access;
        st_access: state_q <= pready ? st_idle : st_access;
        default:   state_q <= st_idle;
      endcase
    end
  end

  assign psel    = (phase != st_idle);
  assign penable = (phase == st_access);

  // the instruction is held by stall, so address and control stay stable for the transfer
  assign paddr  = addr;
  assign pwrite = mem_w;
  assign pwdata = wdata;

  assign stall = (phase == st_setup) | (penable & ~pready);

  // the slave error response is not reported, a load takes prdata as it is
  assign load_data = prdata;

endmodule

`default_nettype wire

// File: verilog/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result #(
  parameter logic [31:0] reset_pc = 32'd0
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 stall,
  input  wire logic                 reg_w,
  input  wire rv_core_pkg::wb_src_t wb_src,
  input  wire logic                 jump,
  input  wire logic [31:0]          alu_result,
  input  wire logic [31:0]          load_data,
  output logic [31:0]               pc,
  output logic                      rf_we,
  output logic [31:0]               rf_wd
);

  logic [31:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  // a stalled memory instruction keeps its pc until the transfer completes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (!stall) begin
      pc <= jump ? alu_result : pc_plus4;
    end
  end

  always_comb begin
    case (wb_src)
      rv_core_pkg::wb_mem: rf_wd = load_data;
      rv_core_pkg::wb_pc4: rf_wd = pc_plus4;
      default:             rf_wd = alu_result;
    endcase
  end

  // the write lands on the same edge that advances the pc
  assign rf_we = reg_w & ~stall;

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter logic [31:0] reset_pc = 32'd0
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  output logic [31:0]      instr_addr,
  input  wire logic [31:0] instr_data,
  output logic [31:0]      paddr,
  output logic             psel,
  output logic             penable,
  output logic             pwrite,
  output logic [31:0]      pwdata,
  input  wire logic [31:0] prdata,
  input  wire logic        pready,
  input  wire logic        pslverr
);

  logic                 alu_src;
  logic                 reg_w;
  logic                 mem_r;
  logic                 mem_w;
  logic                 jump;
  logic                 use_pc;
  rv_core_pkg::alu_op_t alu_op;
  rv_core_pkg::wb_src_t wb_src;
  logic [31:0]          imm;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [4:0]           rd;
  logic [2:0]           funct3;
  logic                 funct7_alt;
  logic [31:0]          rs1_data;
  logic [31:0]          rs2_data;
  logic [31:0]          alu_result;
  logic                 stall;
  logic [31:0]          load_data;
  logic [31:0]          pc;
  logic                 rf_we;
  logic [31:0]          rf_wd;

  assign instr_addr = pc;

  // only AUIPC forces an add that writes the ALU result, JAL is flagged by jump
  assign use_pc = jump |
                  (alu_op == rv_core_pkg::alu_op_add && reg_w && wb_src == rv_core_pkg::wb_alu);

  rv_decode u_decode (
    .instr      (instr_data),
    .alu_src    (alu_src),
    .reg_w      (reg_w),
    .mem_r      (mem_r),
    .mem_w      (mem_w),
    .jump       (jump),
    .alu_op     (alu_op),
    .wb_src     (wb_src),
    .imm        (imm),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .funct3     (funct3),
    .funct7_alt (funct7_alt)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .we       (rf_we),
    .rd       (rd),
    .wd       (rf_wd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .imm        (imm),
    .alu_src    (alu_src),
    .alu_op     (alu_op),
    .funct3     (funct3),
    .funct7_alt (funct7_alt),
    .use_pc     (use_pc),
    .alu_result (alu_result)
  );

  rv_lsu_apb u_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_r     (mem_r),
    .mem_w     (mem_w),
    .addr      (alu_result),
    .wdata     (rs2_data),
    .stall     (stall),
    .load_data (load_data),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  rv_result #(
    .reset_pc (reset_pc)
  ) u_result (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .reg_w      (reg_w),
    .wb_src     (wb_src),
    .jump       (jump),
    .alu_result (alu_result),
    .load_data  (load_data),
    .pc         (pc),
    .rf_we      (rf_we),
    .rf_wd      (rf_wd)
  );

endmodule

`default_nettype wire

// File: verification/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic [31:0] instr_addr,
  input wire logic [31:0] paddr,
  input wire logic        psel,
  input wire logic        penable,
  input wire logic        pwrite,
  input wire logic [31:0] pwdata,
  input wire logic        pready
);

  int assertion_failures = 0;

  penable_with_psel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
    else begin
      assertion_failures++;
      $error("penable is high while psel is low");
    end

  // address and control hold from setup until the access phase completes
  transfer_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
    else begin
      assertion_failures++;
      $error("APB address or control changed during a transfer");
    end

  idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !psel)
    else begin
      assertion_failures++;
      $error("psel is high in the first cycle after reset");
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n) instr_addr[1:0] == 2'b00)
    else begin
      assertion_failures++;
      $error("instr_addr is not word aligned");
    end

endmodule

bind rv_core rv_core_assertions u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .instr_addr (instr_addr),
  .paddr      (paddr),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .pwdata     (pwdata),
  .pready     (pready)
);

`default_nettype wire

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam logic [31:0] reset_pc = 32'h0000_0100;
  localparam int rom_words = 64;
  localparam int max_cycles = 2000;
  localparam int max_busy = 10;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_addr;
  logic [31:0] instr_data;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] rom [0:rom_words-1];
  int          prog_len;
  logic [31:0] load_addr_q [$];
  logic [31:0] load_data_q [$];
  logic [31:0] store_addr_q [$];
  logic [31:0] store_data_q [$];
  int          wait_table [0:63];
  int          wait_left;
  int          busy_cycles;
  int          xfer_count;

  rv_core #(
    .reset_pc (reset_pc)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // instruction ROM answers in the same cycle, outside the program it returns no-op words
  always_comb begin
    if (instr_addr >= reset_pc && instr_addr < reset_pc + 4 * rom_words) begin
      instr_data = rom[(instr_addr - reset_pc) >> 2];
    end else begin
      instr_data = {instr_addr[31:7] ^ {20'd0, instr_addr[6:2]}, 7'b1111111};
    end
  end

  task automatic stop_with_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic load_program();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    // unused words hold an unknown opcode tagged with their own word address
    for (int i = 0; i < rom_words; i++) begin
      rom[i] = {i[24:0], 7'b1111111};
    end
    prog_len = 0;
    fd = $fopen("verification/program_input.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file verification/program_input.txt could not be opened");
      stop_with_failure();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%c %h %h", kind, a, b);
        if (n >= 2 && kind == "I" && prog_len < rom_words) begin
          rom[prog_len] = a;
          prog_len++;
        end else if (n == 3 && kind == "L") begin
          load_addr_q.push_back(a);
          load_data_q.push_back(b);
        end else if (n == 3 && kind == "S") begin
          store_addr_q.push_back(a);
          store_data_q.push_back(b);
        end
      end
      $fclose(fd);
    end
  endtask

  // a write is checked against the next S line, a read takes the next L line
  task automatic complete_transfer();
    if (pwrite && store_addr_q.size() == 0) begin
      $display("the core issued an APB write at %0t ns that no S line expects", $time);
      stop_with_failure();
    end else if (!pwrite && load_addr_q.size() == 0) begin
      $display("the core issued an APB read at %0t ns that no L line expects", $time);
      stop_with_failure();
    end else if (pwrite) begin
      check_value("paddr", paddr, store_addr_q.pop_front());
      check_value("pwdata", pwdata, store_data_q.pop_front());
    end else begin
      check_value("paddr", paddr, load_addr_q.pop_front());
      prdata = load_data_q.pop_front();
    end
  endtask

  // APB slave, the number of wait states is fixed when the setup phase is seen
  always @(negedge clk) begin
    pready = 1'b0;
    if (rst_n && psel === 1'b1) begin
      busy_cycles++;
      if (penable !== 1'b1) begin
        wait_left = wait_table[xfer_count % 64];
        busy_cycles = 0;
      end else if (busy_cycles > max_busy) begin
        $display("the core stalled in an APB transfer at %0t ns", $time);
        stop_with_failure();
      end else if (wait_left > 0) begin
        wait_left--;
      end else begin
        complete_transfer();
        pready = 1'b1;
        xfer_count++;
      end
    end
  end

  initial begin
    int          cycles;
    logic [31:0] end_addr;
    rst_n = 1'b0;
    prdata = 32'd0;
    pready = 1'b0;
    pslverr = 1'b0;
    wait_left = 0;
    busy_cycles = 0;
    xfer_count = 0;
    void'($urandom(66234));
    for (int i = 0; i < 64; i++) begin
      wait_table[i] = $urandom_range(3, 0);
    end
    load_program();
    end_addr = reset_pc + 4 * prog_len;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_value("instr_addr", instr_addr, reset_pc);
    check_value("psel", {31'd0, psel}, 32'd0);

    // the first instruction is not a memory access, so the pc moves on the next edge
    cycles = 0;
    while (instr_addr === reset_pc) begin
      @(negedge clk);
      cycles++;
      if (cycles > 4) begin
        $display("the core stalled at the reset address");
        stop_with_failure();
      end
    end
    check_value("instr_addr", instr_addr, reset_pc + 32'd4);

    cycles = 0;
    while (instr_addr !== end_addr) begin
      @(negedge clk);
      cycles++;
      if (UUT.u_assertions.assertion_failures != 0) begin
        $display("an APB or fetch assertion failed at %0t ns", $time);
        stop_with_failure();
      end else if (cycles > max_cycles) begin
        $display("the core stalled before reaching the end of the program");
        stop_with_failure();
      end
    end

    check_value("stores left", store_addr_q.size(), 32'd0);
    check_value("loads left", load_addr_q.size(), 32'd0);
    if (UUT.u_assertions.assertion_failures == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("an APB or fetch assertion failed during the run");
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: verification/program_input.txt
# I word: instruction at reset_pc + 4 * n | L addr data: load address and returned data
# S addr data: expected APB write, in order | values are hex, text after them is ignored
I 00500093 addi x1, x0, 5
I FFD00113 addi x2, x0, -3
I 002081B3 add x3, x1, x2
I 40208233 sub x4, x1, x2
I 0020C2B3 xor x5, x1, x2
I 00112333 slt x6, x2, x1
I 40115393 srai x7, x2, 1
I 20000513 addi x10, x0, 0x200
I 00352023 sw x3, 0(x10)
I 00452223 sw x4, 4(x10)
I 00552423 sw x5, 8(x10)
I 00652623 sw x6, 12(x10)
I 00752823 sw x7, 16(x10)
I 02052403 lw x8, 32(x10)
I 001404B3 add x9, x8, x1
I 00952A23 sw x9, 20(x10)
I 00012597 auipc x11, 0x12
I 00B52C23 sw x11, 24(x10)
I 00C0066F jal x12, +12
I 06152E23 sw x1, 124(x10) skipped
I 06152E23 sw x1, 124(x10) skipped
I 00C52E23 sw x12, 28(x10)
I 06300013 addi x0, x0, 99
I 02052223 sw x0, 36(x10)
I 00A5108B unknown opcode
I 02152423 sw x1, 40(x10)
I 04052683 lw x13, 64(x10)
I 02D52623 sw x13, 44(x10)
L 00000220 12345678
L 00000240 CAFEF00D
S 00000200 00000002
S 00000204 00000008
S 00000208 FFFFFFF8
S 0000020C 00000001
S 00000210 FFFFFFFE
S 00000214 1234567D
S 00000218 00012140
S 0000021C 0000014C
S 00000224 00000000
S 00000228 00000005
S 0000022C CAFEF00D

// File: rv_core.f
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_regfile.sv
verilog/rv_lsu_apb.sv
verilog/rv_result.sv
verilog/rv_core.sv
verification/rv_core_assertions.sv
verification/rv_core_tb.sv
